//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_forth
FILELIST  = forth_core.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- forth_core.f
hw/forth_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/outer_interp.sv
hw/token_queue.sv
hw/inner_interp.sv
hw/forth_top.sv
testbench/tb_clock.sv
testbench/tb_forth.sv

//--- hw/forth_pkg.sv
// Forth machine shared definitions
// Cell and token types, opcode set and boot ROM entry points

package forth_pkg;

	// Data path widths
	localparam int cell_w = 32;
	localparam int rom_addr_w = 6;

	typedef logic [cell_w-1:0] cell_t;
	typedef logic [rom_addr_w-1:0] xt_t;

	// Opcodes sit in the low 16 bits of a boot ROM cell
	typedef enum logic [15:0] {
		op_execute, op_lit, op_branch, op_0branch,
		op_dup, op_drop, op_plus, op_minus,
		op_equal, op_zero_equal, op_and, op_or,
		op_io_led, op_emit, op_number
	} op_e;

	// One queued token, XT plus number value
	typedef struct packed {
		xt_t xt;
		cell_t value;
	} token_t;

	//////////////////////////////////////////////////////////////////////
	// Boot ROM entry points
	//////////////////////////////////////////////////////////////////////

	// Must follow the handler order in the inner interpreter ROM
	localparam xt_t xt_error = 6'd1;
	localparam xt_t xt_red = 6'd6;
	localparam xt_t xt_green = 6'd11;
	localparam xt_t xt_blue = 6'd16;
	localparam xt_t xt_number = 6'd21;
	localparam xt_t xt_led = 6'd24;
	localparam xt_t xt_dot = 6'd27;
	localparam xt_t xt_plus = 6'd36;
	localparam xt_t xt_minus = 6'd39;

endpackage

//--- hw/forth_top.sv
// Forth machine top level
// UART in, outer interpreter, token queue, inner interpreter, UART out

`timescale 1ns/1ps

module forth_top #(
	parameter int clks_per_bit = 625,
	parameter int queue_depth = 8,
	parameter int stack_depth = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx,
	output logic led_g,
	output logic led_b,
	output logic led_r
);

	import forth_pkg::*;

	// Receive side
	logic       rx_req;
	logic       rx_ack;
	logic [7:0] rx_byte;

	// Token path
	logic   push;
	logic   pop;
	logic   empty;
	logic   full;
	token_t in_token;
	token_t head;

	// Transmit side
	logic       tx_req;
	logic       tx_ack;
	logic [7:0] tx_byte;

	uart_rx #(.clks_per_bit(clks_per_bit)) u_uart_rx (
		.clk(clk), .reset(reset), .rx(rx),
		.rx_ack(rx_ack), .rx_req(rx_req), .rx_byte(rx_byte)
	);

	outer_interp u_outer (
		.clk(clk), .reset(reset), .rx_req(rx_req), .rx_byte(rx_byte),
		.full(full), .rx_ack(rx_ack), .push(push), .token(in_token)
	);

	token_queue #(.queue_depth(queue_depth)) u_queue (
		.clk(clk), .reset(reset), .push(push), .token(in_token),
		.pop(pop), .head(head), .empty(empty), .full(full)
	);

	inner_interp #(.stack_depth(stack_depth)) u_inner (
		.clk(clk), .reset(reset), .empty(empty), .head(head),
		.tx_ack(tx_ack), .pop(pop), .tx_req(tx_req), .tx_byte(tx_byte),
		.led_g(led_g), .led_b(led_b), .led_r(led_r)
	);

	uart_tx #(.clks_per_bit(clks_per_bit)) u_uart_tx (
		.clk(clk), .reset(reset), .tx_req(tx_req),
		.tx_byte(tx_byte), .tx(tx), .tx_ack(tx_ack)
	);

endmodule

//--- hw/inner_interp.sv
// Forth inner interpreter
// Boot ROM, fetch/execute unit, circular data stack and LED outputs

`timescale 1ns/1ps

module inner_interp #(
	parameter int stack_depth = 16
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              empty,
	input  forth_pkg::token_t head,
	input  logic              tx_ack,
	output logic              pop,
	output logic              tx_req,
	output logic [7:0]        tx_byte,
	output logic              led_g,
	output logic              led_b,
	output logic              led_r
);

	import forth_pkg::*;

	localparam int rom_len = 42;
	localparam int dp_w = $clog2(stack_depth);

	//////////////////////////////////////////////////////////////////////
	// Boot ROM, one handler per word, each back to execute at 0
	//////////////////////////////////////////////////////////////////////

	localparam cell_t boot_rom [rom_len] = '{
		cell_t'(op_execute),
		// xt_error
		cell_t'(op_lit), cell_t'("?"), cell_t'(op_emit), cell_t'(op_branch), cell_t'(0),
		// xt_red, xt_green, xt_blue
		cell_t'(op_lit), cell_t'(4), cell_t'(op_io_led), cell_t'(op_branch), cell_t'(0),
		cell_t'(op_lit), cell_t'(1), cell_t'(op_io_led), cell_t'(op_branch), cell_t'(0),
		cell_t'(op_lit), cell_t'(2), cell_t'(op_io_led), cell_t'(op_branch), cell_t'(0),
		// xt_number
		cell_t'(op_number), cell_t'(op_branch), cell_t'(0),
		// xt_led
		cell_t'(op_io_led), cell_t'(op_branch), cell_t'(0),
		// xt_dot, digit then a space
		cell_t'(op_lit), cell_t'("0"), cell_t'(op_plus), cell_t'(op_emit),
		cell_t'(op_lit), cell_t'(" "), cell_t'(op_emit), cell_t'(op_branch), cell_t'(0),
		// xt_plus, xt_minus
		cell_t'(op_plus), cell_t'(op_branch), cell_t'(0),
		cell_t'(op_minus), cell_t'(op_branch), cell_t'(0)
	};

	typedef enum logic [1:0] {fetch, operand, emit_wait} phase_e;

	phase_e phase;
	xt_t pc;
	cell_t rom_cell;
	op_e op;
	// Opcode waiting for its inline cell
	op_e op_r;
	// Value of the last popped token
	cell_t num_r;

	cell_t stack [stack_depth];
	logic [dp_w-1:0] dp;
	logic [dp_w-1:0] dp_up;
	logic [dp_w-1:0] dp_dn;
	cell_t tos;
	cell_t nos;

	assign rom_cell = boot_rom[pc];
	assign op = op_e'(rom_cell[15:0]);
	// Stack pointer wraps
	assign dp_up = dp + 1'b1;
	assign dp_dn = dp - 1'b1;
	assign tos = stack[dp];
	assign nos = stack[dp_dn];
	assign pop = phase == fetch && op == op_execute && !empty;

	always_ff @(posedge clk) begin
		if (!reset) begin
			phase <= fetch;
			pc <= '0;
			dp <= '0;
			tx_req <= 1'b0;
			led_g <= 1'b1;
			led_b <= 1'b1;
			led_r <= 1'b1;
		end else begin
			case (phase)
				fetch: begin
					pc <= pc + 1'b1;
					case (op)
						// Wait for a token, then jump to its handler
						op_execute: begin
							pc <= empty ? pc : head.xt;
							if (!empty)
								num_r <= head.value;
						end
						op_lit, op_branch, op_0branch: begin
							op_r <= op;
							phase <= operand;
						end
						op_dup: begin
							stack[dp_up] <= tos;
							dp <= dp_up;
						end
						op_drop: dp <= dp_dn;
						op_plus: begin
							stack[dp_dn] <= nos + tos;
							dp <= dp_dn;
						end
						// Second minus top
						op_minus: begin
							stack[dp_dn] <= nos - tos;
							dp <= dp_dn;
						end
						op_equal: begin
							stack[dp_dn] <= nos == tos ? '1 : '0;
							dp <= dp_dn;
						end
						op_zero_equal: stack[dp] <= tos == '0 ? '1 : '0;
						op_and: begin
							stack[dp_dn] <= nos & tos;
							dp <= dp_dn;
						end
						op_or: begin
							stack[dp_dn] <= nos | tos;
							dp <= dp_dn;
						end
						// LEDs active low, bit 0 green, 1 blue, 2 red
						op_io_led: begin
							led_g <= !tos[0];
							led_b <= !tos[1];
							led_r <= !tos[2];
							dp <= dp_dn;
						end
						op_emit: begin
							tx_byte <= tos[7:0];
							tx_req <= 1'b1;
							dp <= dp_dn;
							phase <= emit_wait;
						end
						op_number: begin
							stack[dp_up] <= num_r;
							dp <= dp_up;
						end
						default: ;
					endcase
				end
				// Inline cell read
				operand: begin
					phase <= fetch;
					pc <= pc + 1'b1;
					case (op_r)
						op_lit: begin
							stack[dp_up] <= rom_cell;
							dp <= dp_up;
						end
						op_branch: pc <= rom_cell[rom_addr_w-1:0];
						op_0branch: begin
							if (tos == '0)
								pc <= rom_cell[rom_addr_w-1:0];
							dp <= dp_dn;
						end
						default: ;
					endcase
				end
				// Drop request on ack, resume once ack is gone
				emit_wait: begin
					if (tx_req && tx_ack)
						tx_req <= 1'b0;
					else if (!tx_req && !tx_ack)
						phase <= fetch;
				end
				default: phase <= fetch;
			endcase
		end
	end

endmodule

//--- hw/outer_interp.sv
// Forth outer interpreter
// Splits received characters into words and searches the ROM dictionary
// Found words give their XT, single digits a number, the rest an error

`timescale 1ns/1ps

module outer_interp (
	input  logic             clk,
	input  logic             reset,
	input  logic             rx_req,
	input  logic [7:0]       rx_byte,
	input  logic             full,
	output logic             rx_ack,
	output logic             push,
	output forth_pkg::token_t token
);

	import forth_pkg::*;

	localparam int dict_len = 23;
	localparam int dict_addr_w = 5;

	//////////////////////////////////////////////////////////////////////
	// Dictionary ROM
	//////////////////////////////////////////////////////////////////////

	// Entry is link, name cells, XT; link 0 ends the chain
	// First name cell holds the cell count in its top byte
	localparam cell_t dict [dict_len] = '{
		cell_t'(3), {8'd1, "red"}, cell_t'(xt_red),
		cell_t'(7), {8'd2, "gre"}, {"en", 16'h0}, cell_t'(xt_green),
		cell_t'(11), {8'd2, "blu"}, {"e", 24'h0}, cell_t'(xt_blue),
		cell_t'(14), {8'd1, "led"}, cell_t'(xt_led),
		cell_t'(17), {8'd1, ".", 16'h0}, cell_t'(xt_dot),
		cell_t'(20), {8'd1, "+", 16'h0}, cell_t'(xt_plus),
		cell_t'(0), {8'd1, "-", 16'h0}, cell_t'(xt_minus)
	};

	typedef enum logic [2:0] {
		idle, collect, get_link, search, get_xt, emit_token
	} state_e;

	state_e state;
	logic [7:0] byte_in;
	// Up to eight characters in three cells
	cell_t word [3];
	logic [3:0] n_chars;
	logic [3:0] pos;
	logic [1:0] n_cells;
	logic [1:0] ccell;
	logic [dict_addr_w-1:0] wp;
	logic [dict_addr_w-1:0] link_addr;
	logic is_digit;
	logic is_delim;

	assign pos = n_chars + 1'b1;
	assign n_cells = word[0][25:24];
	assign is_digit = n_chars == 4'd1 && word[0][23:16] inside {["0":"9"]};
	assign is_delim = rx_byte_is_delim(byte_in);
	assign push = state == emit_token && !full;

	function automatic logic rx_byte_is_delim(logic [7:0] c);
		return c == " " || c == 8'd10 || c == 8'd13;
	endfunction

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			rx_ack <= 1'b0;
			n_chars <= '0;
			word <= '{default: '0};
			wp <= '0;
			link_addr <= '0;
			ccell <= '0;
		end else begin
			// Ack released once the receiver drops its request
			if (rx_ack && !rx_req)
				rx_ack <= 1'b0;
			case (state)
				idle: if (rx_req && !rx_ack) begin
					byte_in <= rx_byte;
					rx_ack <= 1'b1;
					state <= collect;
				end
				collect: begin
					state <= idle;
					if (is_delim) begin
						// Empty word gives no token
						if (n_chars != '0) begin
							wp <= '0;
							state <= get_link;
						end
					end else if (n_chars < 4'd8) begin
						word[pos[3:2]][{~pos[1:0], 3'b000} +: 8] <= byte_in;
						word[0][31:24] <= 8'(pos[3:2]) + 8'd1;
						n_chars <= pos;
					end
				end
				get_link: begin
					link_addr <= dict[wp][dict_addr_w-1:0];
					wp <= wp + 1'b1;
					ccell <= '0;
					state <= search;
				end
				// One name cell per cycle
				search: if (ccell == n_cells) begin
					state <= get_xt;
				end else if (dict[wp] == word[ccell]) begin
					wp <= wp + 1'b1;
					ccell <= ccell + 1'b1;
				end else if (link_addr != '0) begin
					wp <= link_addr;
					state <= get_link;
				end else begin
					// End of chain, digit or error
					token.xt <= is_digit ? xt_number : xt_error;
					token.value <= is_digit ? cell_t'(word[0][23:16] - "0") : '0;
					state <= emit_token;
				end
				get_xt: begin
					token.xt <= dict[wp][rom_addr_w-1:0];
					token.value <= '0;
					state <= emit_token;
				end
				// Stall here while the queue is full
				emit_token: if (!full) begin
					word <= '{default: '0};
					n_chars <= '0;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

//--- hw/token_queue.sv
// Token FIFO between the outer and inner interpreters
// Circular buffer with head visible at all times

`timescale 1ns/1ps

module token_queue #(
	parameter int queue_depth = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  forth_pkg::token_t token,
	input  logic              pop,
	output forth_pkg::token_t head,
	output logic              empty,
	output logic              full
);

	import forth_pkg::*;

	localparam int ptr_w = $clog2(queue_depth);
	localparam logic [ptr_w-1:0] last = ptr_w'(queue_depth - 1);

	token_t mem [queue_depth];
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w:0] count;

	assign head = mem[rd_ptr];
	assign empty = count == '0;
	assign full = count == (ptr_w + 1)'(queue_depth);

	// Storage has no reset
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= token;
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr == last ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr == last ? '0 : rd_ptr + 1'b1;
			count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
		end
	end

	assert property (@(posedge clk) disable iff (!reset) push |-> !full)
		else $error("push into full token queue");
	assert property (@(posedge clk) disable iff (!reset) pop |-> !empty)
		else $error("pop from empty token queue");

endmodule

//--- hw/uart_rx.sv
// UART receiver
// Receives 8N1 frames at a fixed clock count per bit and hands each byte on by req/ack

`timescale 1ns/1ps

module uart_rx #(
	parameter int clks_per_bit = 625
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	input  logic       rx_ack,
	output logic       rx_req,
	output logic [7:0] rx_byte
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] half_end = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);

	typedef enum logic [2:0] {idle, start, data, stop, hold} state_e;

	state_e state;
	logic [cnt_w-1:0] cnt;
	logic [2:0] bit_idx;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			cnt <= '0;
			bit_idx <= '0;
			rx_req <= 1'b0;
		end else begin
			case (state)
				// No new frame until the last ack has dropped
				idle: if (!rx && !rx_ack) begin
					cnt <= '0;
					state <= start;
				end
				// Recheck start bit at mid-bit so glitches go back to idle
				start: if (cnt == half_end) begin
					cnt <= '0;
					bit_idx <= '0;
					state <= rx ? idle : data;
				end else begin
					cnt <= cnt + 1'b1;
				end
				// LSB first into the top of the shifter
				data: if (cnt == bit_end) begin
					cnt <= '0;
					rx_byte <= {rx, rx_byte[7:1]};
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= stop;
				end else begin
					cnt <= cnt + 1'b1;
				end
				// Bad stop bit drops the frame
				stop: if (cnt == bit_end) begin
					cnt <= '0;
					rx_req <= rx;
					state <= rx ? hold : idle;
				end else begin
					cnt <= cnt + 1'b1;
				end
				hold: if (rx_ack) begin
					rx_req <= 1'b0;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Ack only answers a pending request
	assert property (@(posedge clk) disable iff (!reset) $rose(rx_ack) |-> rx_req)
		else $error("rx_ack raised without rx_req");

endmodule

//--- hw/uart_tx.sv
// UART transmitter
// Takes one byte per req/ack cycle and sends an 8N1 frame

`timescale 1ns/1ps

module uart_tx #(
	parameter int clks_per_bit = 625
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_req,
	input  logic [7:0] tx_byte,
	output logic       tx,
	output logic       tx_ack
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);

	typedef enum logic [1:0] {idle, send, done} state_e;

	state_e state;
	logic [cnt_w-1:0] cnt;
	logic [3:0] bit_idx;
	// Data bits then the stop bit
	logic [8:0] shifter;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= idle;
			tx <= 1'b1;
			tx_ack <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				// Start bit goes out on the edge that sees the request
				idle: if (tx_req && !tx_ack) begin
					shifter <= {1'b1, tx_byte};
					tx <= 1'b0;
					cnt <= '0;
					bit_idx <= '0;
					state <= send;
				end
				send: if (cnt == bit_end) begin
					cnt <= '0;
					if (bit_idx == 4'd9) begin
						// Stop bit finished
						tx_ack <= 1'b1;
						state <= done;
					end else begin
						tx <= shifter[0];
						shifter <= {1'b1, shifter[8:1]};
						bit_idx <= bit_idx + 1'b1;
					end
				end else begin
					cnt <= cnt + 1'b1;
				end
				done: if (!tx_req) begin
					tx_ack <= 1'b0;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Four-phase rule, request held until acknowledged
	assert property (@(posedge clk) disable iff (!reset) $fell(tx_req) |-> tx_ack)
		else $error("tx_req dropped before tx_ack");

endmodule

//--- testbench/tb_clock.sv
// Testbench clock and reset
// Free running clock, active-low reset released after a few cycles

`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 100,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Released on a falling edge like all other stimulus
	initial begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
	end

endmodule

//--- testbench/tb_forth.sv
// Forth machine testbench
// Directed tests over the serial line, UART driver on rx and monitor on tx

`timescale 1ns/1ps

module tb_forth;

	localparam int clks_per_bit = 16;
	// Longest line plus its reply fits well inside this
	localparam int char_timeout = 4000;
	localparam int settle_timeout = 400;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic led_g;
	logic led_b;
	logic led_r;
	logic [2:0] leds;

	int errors = 0;
	int checks = 0;

	assign leds = {led_r, led_g, led_b};

	tb_clock #(.period(100), .reset_cycles(4)) u_clock (.clk(clk), .reset(reset));

	forth_top #(.clks_per_bit(clks_per_bit)) uut (
		.clk(clk), .reset(reset), .rx(rx), .tx(tx),
		.led_g(led_g), .led_b(led_b), .led_r(led_r)
	);

	//////////////////////////////////////////////////////////////////////
	// UART driver and monitor
	//////////////////////////////////////////////////////////////////////

	// Start bit, 8 data bits LSB first, stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (clks_per_bit - 1) @(negedge clk);
		end
	endtask

	// Whole line, then CR as the last delimiter
	task automatic send_line(input string line);
		for (int i = 0; i < line.len(); i++)
			send_byte(line[i]);
		send_byte(8'd13);
	endtask

	task automatic receive_char(input string test, output logic [7:0] c, output bit ok);
		int waited;
		ok = 1'b0;
		c = 8'h00;
		waited = 0;
		@(negedge clk);
		while (tx !== 1'b0 && waited < char_timeout) begin
			@(negedge clk);
			waited++;
		end
		if (tx !== 1'b0) begin
			$display("%s: no start bit on tx within %0d cycles", test, char_timeout);
			errors++;
			return;
		end
		// To mid-bit of the start bit
		repeat (clks_per_bit / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			$display("%s: start bit on tx too short", test);
			errors++;
			return;
		end
		for (int i = 0; i < 8; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			c[i] = tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		if (tx !== 1'b1) begin
			$display("%s: stop bit on tx missing", test);
			errors++;
			return;
		end
		ok = 1'b1;
	endtask

	task automatic expect_output(input string test, input string expected);
		logic [7:0] c;
		bit ok;
		for (int i = 0; i < expected.len(); i++) begin
			receive_char(test, c, ok);
			if (!ok)
				return;
			checks++;
			if (c !== expected[i]) begin
				$display("FAILED %s: expected 0x%02h, actual 0x%02h", test, expected[i], c);
				errors++;
			end
		end
	endtask

	// Reply may start before the CR frame ends
	task automatic run_line(input string test, input string line, input string expected);
		fork
			send_line(line);
			expect_output(test, expected);
		join
	endtask

	// Active low, bit 0 green, bit 1 blue, bit 2 red
	function automatic logic [2:0] led_pattern(input int unsigned value);
		return {~value[2], ~value[0], ~value[1]};
	endfunction

	task automatic check_leds(input string test, input logic [2:0] expected);
		int waited;
		waited = 0;
		while (leds !== expected && waited < settle_timeout) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		if (leds !== expected) begin
			$display("FAILED %s: expected rgb %03b, actual %03b", test, expected, leds);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		int waited;
		bit bad;
		waited = 0;
		bad = 1'b0;
		while (reset !== 1'b1 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (reset !== 1'b1) begin
			$display("after_reset: reset was never released");
			errors++;
			return;
		end
		// Line idle, LEDs off
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			if (!bad && (tx !== 1'b1 || leds !== 3'b111)) begin
				$display("FAILED after_reset: expected tx/rgb 1/111, actual %b/%03b", tx, leds);
				errors++;
				bad = 1'b1;
			end
		end
		checks++;
	endtask

	task automatic test_led_words();
		send_line("red");
		check_leds("led_red", 3'b011);
		send_line("green");
		check_leds("led_green", 3'b101);
		send_line("blue");
		check_leds("led_blue", 3'b110);
	endtask

	task automatic test_arithmetic();
		int unsigned a;
		int unsigned b;
		// Sum stays a single digit
		a = $urandom % 10;
		b = $urandom % (10 - a);
		run_line("add", $sformatf("%0d %0d + .", a, b), $sformatf("%0d ", a + b));
		// Second minus top, never negative
		a = $urandom % 10;
		b = $urandom % (a + 1);
		run_line("subtract", $sformatf("%0d %0d - .", a, b), $sformatf("%0d ", a - b));
	endtask

	task automatic test_unknown();
		run_line("unknown_word", "xyz", "?");
		run_line("two_digits", "12", "?");
	endtask

	task automatic test_stack_leds();
		send_line("5 led");
		check_leds("stack_leds", led_pattern(5));
	endtask

	initial begin
		rx = 1'b1;
		void'($urandom(32'h90d2cf9b));
		test_reset();
		test_led_words();
		test_arithmetic();
		test_unknown();
		test_stack_leds();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
